// File: Bender.yml
package:
  name: l1_cache

sources:
  - include_dirs:
      - common
    files:
      - common/l1_cache_pkg.sv
      - common/cache_array_if.sv
      - source/l1_cache_sram.sv
      - l1_cache/l1_cache_controller.sv
      - l1_cache/l1_cache_datapath.sv
      - l1_cache/l1_cache.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/l1_cache_checker.sv
      - sim/l1_cache_monitor.sv
      - sim/l1_cache_tb.sv

// File: common/cache_array_if.sv
`timescale 1ns/1ps

interface cache_array_if;

	// status from the datapath
	logic hit;
	logic victim_dirty;

	// control from the controller
	logic array_we;
	logic dirty_wr;
	logic fill_from_dram;
	logic victim_addr_sel;

	modport ctrl (
		input  hit,
		input  victim_dirty,
		output array_we,
		output dirty_wr,
		output fill_from_dram,
		output victim_addr_sel
	);

	modport dp (
		output hit,
		output victim_dirty,
		input  array_we,
		input  dirty_wr,
		input  fill_from_dram,
		input  victim_addr_sel
	);

endinterface

// File: common/l1_cache_pkg.sv
package l1_cache_pkg;

	// controller states
	// idle waits for a cpu strobe
	// compare checks the registered tag read
	// writeback sends a dirty victim line to dram
	// allocate fetches the requested line from dram
	typedef enum logic [1:0] {
		ST_IDLE      = 2'd0,
		ST_COMPARE   = 2'd1,
		ST_WRITEBACK = 2'd2,
		ST_ALLOCATE  = 2'd3
	} ctrl_state_e;

endpackage

// File: common/l1_cache_settings.svh
`ifndef L1_CACHE_SETTINGS_SVH
`define L1_CACHE_SETTINGS_SVH

// bus widths
`define ADDR_WIDTH      32
`define CPU_DATA_WIDTH  32
`define MEM_DATA_WIDTH  256

// address split, tag | index | byte offset
`define TAG_BITS        22
`define INDEX_BITS      5
`define OFFSET_BITS     5

// upper offset bits pick the word inside a line
`define WORD_SEL_BITS   3

`define LINE_COUNT      32

// valid bit, dirty bit and tag
`define TAG_ENTRY_BITS  24

`endif

// File: files.f
+incdir+common
common/l1_cache_pkg.sv
common/cache_array_if.sv
source/l1_cache_sram.sv
l1_cache/l1_cache_controller.sv
l1_cache/l1_cache_datapath.sv
l1_cache/l1_cache.sv
sim/l1_cache_checker.sv
sim/l1_cache_monitor.sv
sim/l1_cache_tb.sv

// File: l1_cache/l1_cache.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module l1_cache (
	input  logic                       clk_i,
	input  logic                       rst_n_i,

	// cpu side
	input  logic [`ADDR_WIDTH-1:0]     cache_addr_i,
	input  logic                       cache_cs_i,
	input  logic                       cache_we_i,
	output logic                       cache_ack_o,
	input  logic [`CPU_DATA_WIDTH-1:0] cache_data_i,
	output logic [`CPU_DATA_WIDTH-1:0] cache_data_o,

	// dram side
	output logic [`ADDR_WIDTH-1:0]     dram_addr_o,
	output logic                       dram_cs_o,
	output logic                       dram_we_o,
	input  logic                       dram_ack_i,
	input  logic [`MEM_DATA_WIDTH-1:0] dram_data_i,
	output logic [`MEM_DATA_WIDTH-1:0] dram_data_o
);

	cache_array_if arr_if ();

	l1_cache_controller controller_i (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.cache_cs_i  (cache_cs_i),
		.cache_we_i  (cache_we_i),
		.cache_ack_o (cache_ack_o),
		.dram_cs_o   (dram_cs_o),
		.dram_we_o   (dram_we_o),
		.dram_ack_i  (dram_ack_i),
		.arr         (arr_if.ctrl)
	);

	l1_cache_datapath datapath_i (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.cache_addr_i (cache_addr_i),
		.cache_data_i (cache_data_i),
		.cache_data_o (cache_data_o),
		.dram_addr_o  (dram_addr_o),
		.dram_data_i  (dram_data_i),
		.dram_data_o  (dram_data_o),
		.arr          (arr_if.dp)
	);

endmodule

// File: l1_cache/l1_cache_controller.sv
`timescale 1ns/1ps

module l1_cache_controller
	import l1_cache_pkg::*;
(
	input  logic        clk_i,
	input  logic        rst_n_i,

	// cpu side
	input  logic        cache_cs_i,
	input  logic        cache_we_i,
	output logic        cache_ack_o,

	// dram side
	output logic        dram_cs_o,
	output logic        dram_we_o,
	input  logic        dram_ack_i,

	// datapath status and control
	cache_array_if.ctrl arr
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	logic        ack_d;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q     <= ST_IDLE;
			cache_ack_o <= 1'b0;
		end else begin
			state_q     <= state_d;
			cache_ack_o <= ack_d;
		end
	end

	// next state and ack
	always_comb begin
		state_d = state_q;
		ack_d   = 1'b0;
		case (state_q)
			ST_IDLE: begin
				// a strobe seen together with the ack belongs to the finished request
				if (cache_cs_i && !cache_ack_o) begin
					state_d = ST_COMPARE;
				end
			end
			ST_COMPARE: begin
				if (arr.hit) begin
					ack_d   = 1'b1;
					state_d = ST_IDLE;
				end else if (arr.victim_dirty) begin
					state_d = ST_WRITEBACK;
				end else begin
					state_d = ST_ALLOCATE;
				end
			end
			ST_WRITEBACK: begin
				if (dram_ack_i) begin
					state_d = ST_ALLOCATE;
				end
			end
			ST_ALLOCATE: begin
				// refilled line is visible in the next compare through write-first
				if (dram_ack_i) begin
					state_d = ST_COMPARE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	// array and dram strobes follow the state
	always_comb begin
		arr.array_we        = 1'b0;
		arr.dirty_wr        = 1'b0;
		arr.fill_from_dram  = 1'b0;
		arr.victim_addr_sel = 1'b0;
		dram_cs_o           = 1'b0;
		dram_we_o           = 1'b0;
		case (state_q)
			ST_COMPARE: begin
				// write hit merges the cpu word, line becomes dirty
				arr.array_we = arr.hit && cache_we_i;
				arr.dirty_wr = 1'b1;
			end
			ST_WRITEBACK: begin
				dram_cs_o           = 1'b1;
				dram_we_o           = 1'b1;
				arr.victim_addr_sel = 1'b1;
			end
			ST_ALLOCATE: begin
				dram_cs_o          = 1'b1;
				// store the fetched line clean
				arr.array_we       = dram_ack_i;
				arr.fill_from_dram = 1'b1;
			end
			default: begin
				arr.array_we = 1'b0;
			end
		endcase
	end

endmodule

// File: l1_cache/l1_cache_datapath.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module l1_cache_datapath (
	input  logic                       clk_i,
	input  logic                       rst_n_i,

	// cpu side
	input  logic [`ADDR_WIDTH-1:0]     cache_addr_i,
	input  logic [`CPU_DATA_WIDTH-1:0] cache_data_i,
	output logic [`CPU_DATA_WIDTH-1:0] cache_data_o,

	// dram side
	output logic [`ADDR_WIDTH-1:0]     dram_addr_o,
	input  logic [`MEM_DATA_WIDTH-1:0] dram_data_i,
	output logic [`MEM_DATA_WIDTH-1:0] dram_data_o,

	cache_array_if.dp                  arr
);

	logic [`TAG_BITS-1:0]       req_tag;
	logic [`INDEX_BITS-1:0]     req_index;
	logic [`WORD_SEL_BITS-1:0]  word_sel;
	logic [`TAG_ENTRY_BITS-1:0] tag_entry_rd;
	logic [`TAG_ENTRY_BITS-1:0] tag_entry_wr;
	logic                       stored_valid;
	logic                       stored_dirty;
	logic [`TAG_BITS-1:0]       stored_tag;
	logic [`MEM_DATA_WIDTH-1:0] line_rd;
	logic [`MEM_DATA_WIDTH-1:0] line_merged;
	logic [`MEM_DATA_WIDTH-1:0] line_wr;

	// address split
	assign req_tag   = cache_addr_i[`ADDR_WIDTH-1 -: `TAG_BITS];
	assign req_index = cache_addr_i[`OFFSET_BITS +: `INDEX_BITS];
	assign word_sel  = cache_addr_i[`OFFSET_BITS-1 -: `WORD_SEL_BITS];

	assign {stored_valid, stored_dirty, stored_tag} = tag_entry_rd;

	assign arr.hit          = stored_valid && (stored_tag == req_tag);
	assign arr.victim_dirty = stored_valid && stored_dirty;

	// read word out of the registered line
	assign cache_data_o = line_rd[word_sel*`CPU_DATA_WIDTH +: `CPU_DATA_WIDTH];

	// cpu word dropped into the stored line
	always_comb begin
		line_merged = line_rd;
		line_merged[word_sel*`CPU_DATA_WIDTH +: `CPU_DATA_WIDTH] = cache_data_i;
	end

	assign line_wr      = arr.fill_from_dram ? dram_data_i : line_merged;
	assign tag_entry_wr = {1'b1, arr.dirty_wr, req_tag};

	// victim tag for write-back, request tag for refill
	assign dram_addr_o = {arr.victim_addr_sel ? stored_tag : req_tag, req_index,
		{`OFFSET_BITS{1'b0}}};
	assign dram_data_o = line_rd;

	l1_cache_sram #(
		.WIDTH (`TAG_ENTRY_BITS),
		.DEPTH (`LINE_COUNT)
	) tag_array_i (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.addr_i  (req_index),
		.we_i    (arr.array_we),
		.data_i  (tag_entry_wr),
		.data_o  (tag_entry_rd)
	);

	l1_cache_sram #(
		.WIDTH (`MEM_DATA_WIDTH),
		.DEPTH (`LINE_COUNT)
	) data_array_i (
		.clk_i   (clk_i),
		.rst_n_i (rst_n_i),
		.addr_i  (req_index),
		.we_i    (arr.array_we),
		.data_i  (line_wr),
		.data_o  (line_rd)
	);

endmodule

// File: sim/l1_cache_checker.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module l1_cache_checker (
	input  logic                   clk_i,
	input  logic                   rst_n_i,
	input  logic                   cache_ack_o,
	input  logic                   dram_cs_o,
	input  logic                   dram_ack_i,
	input  logic [`ADDR_WIDTH-1:0] dram_addr_o
);

	int fail_count = 0;

	// ack is a single-cycle pulse
	ack_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		cache_ack_o |=> !cache_ack_o)
		else begin
			$error("cache_ack_o stayed high for more than one cycle");
			fail_count++;
		end

	// a dram request is held until it is answered
	dram_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		dram_cs_o && !dram_ack_i |=> dram_cs_o)
		else begin
			$error("dram_cs_o dropped before dram_ack_i");
			fail_count++;
		end

	dram_align: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		dram_cs_o |-> (dram_addr_o[`OFFSET_BITS-1:0] == '0))
		else begin
			$error("dram_addr_o is not line aligned");
			fail_count++;
		end

endmodule

bind l1_cache l1_cache_checker checker_i (
	.clk_i       (clk_i),
	.rst_n_i     (rst_n_i),
	.cache_ack_o (cache_ack_o),
	.dram_cs_o   (dram_cs_o),
	.dram_ack_i  (dram_ack_i),
	.dram_addr_o (dram_addr_o)
);

// File: sim/l1_cache_monitor.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module l1_cache_monitor (
	input  logic                       clk_i,
	input  logic                       rst_n_i,
	input  logic [`ADDR_WIDTH-1:0]     cache_addr_i,
	input  logic                       cache_cs_i,
	input  logic                       cache_we_i,
	input  logic                       cache_ack_o,
	input  logic [`CPU_DATA_WIDTH-1:0] cache_data_i,
	input  logic [`CPU_DATA_WIDTH-1:0] cache_data_o,
	input  logic [`ADDR_WIDTH-1:0]     dram_addr_o,
	input  logic                       dram_cs_o,
	input  logic                       dram_we_o,
	input  logic                       dram_ack_i,
	input  logic [`MEM_DATA_WIDTH-1:0] dram_data_o,
	output int                         test_count_o,
	output int                         error_count_o
);

	// word-level reference memory, keyed by word-aligned address
	logic [31:0]  ref_mem [logic [31:0]];
	logic         mdl_valid [`LINE_COUNT];
	logic         mdl_dirty [`LINE_COUNT];
	logic [21:0]  mdl_tag [`LINE_COUNT];
	logic         in_req = 1'b0;
	logic         req_we;
	logic         exp_hit;
	logic         exp_wb;
	logic [31:0]  req_addr;
	logic [31:0]  req_data;
	logic [4:0]   req_index;
	logic [21:0]  req_tag;
	int           cycles;
	int           dram_writes;
	int           dram_reads;
	int           req_errors;

	// untouched memory holds a pattern of its own address
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h3c5a_96e1;
	endfunction

	function automatic logic [31:0] ref_word(input logic [31:0] addr);
		logic [31:0] waddr;
		waddr = {addr[31:2], 2'b00};
		if (ref_mem.exists(waddr)) begin
			return ref_mem[waddr];
		end else begin
			return fill_word(waddr);
		end
	endfunction

	function automatic logic [255:0] ref_line(input logic [31:0] line_addr);
		logic [255:0] line;
		for (int w = 0; w < 8; w++) begin
			line[w*32 +: 32] = ref_word(line_addr + 32'(w * 4));
		end
		return line;
	endfunction

	task automatic report_error(input string msg);
		$display("%s", msg);
		error_count_o++;
	endtask

	task automatic start_request();
		in_req      = 1'b1;
		req_addr    = cache_addr_i;
		req_we      = cache_we_i;
		req_data    = cache_data_i;
		req_index   = cache_addr_i[9:5];
		req_tag     = cache_addr_i[31:10];
		cycles      = 0;
		dram_writes = 0;
		dram_reads  = 0;
		req_errors  = error_count_o;
		exp_hit     = mdl_valid[req_index] && (mdl_tag[req_index] == req_tag);
		exp_wb      = !exp_hit && mdl_valid[req_index] && mdl_dirty[req_index];
	endtask

	task automatic check_dram();
		logic [31:0] victim;
		logic [31:0] line_addr;
		victim    = {mdl_tag[req_index], req_index, 5'b0};
		line_addr = {req_addr[31:5], 5'b0};
		if (dram_we_o) begin
			dram_writes++;
			if (!exp_wb || dram_reads != 0) begin
				report_error($sformatf("unexpected dram write at 0x%08h", dram_addr_o));
			end else if (dram_addr_o != victim) begin
				report_error($sformatf("error dram_addr_o expected 0x%08h got 0x%08h",
					victim, dram_addr_o));
			end else if (dram_data_o != ref_line(victim)) begin
				report_error($sformatf("error dram_data_o expected 0x%064h got 0x%064h",
					ref_line(victim), dram_data_o));
			end
		end else begin
			dram_reads++;
			if (exp_hit || (exp_wb && dram_writes == 0)) begin
				report_error($sformatf("dram read at 0x%08h came out of order", dram_addr_o));
			end else if (dram_addr_o != line_addr) begin
				report_error($sformatf("error dram_addr_o expected 0x%08h got 0x%08h",
					line_addr, dram_addr_o));
			end
		end
	endtask

	task automatic finish_request();
		if (dram_writes != int'(exp_wb) || dram_reads != int'(!exp_hit)) begin
			report_error($sformatf("request at 0x%08h made %0d dram writes and %0d reads",
				req_addr, dram_writes, dram_reads));
		end
		if (exp_hit && cycles != 2) begin
			report_error($sformatf("hit at 0x%08h acked after %0d cycles instead of 2",
				req_addr, cycles));
		end
		if (!req_we && cache_data_o != ref_word(req_addr)) begin
			report_error($sformatf("error cache_data_o expected 0x%08h got 0x%08h",
				ref_word(req_addr), cache_data_o));
		end
		if (req_we) begin
			ref_mem[{req_addr[31:2], 2'b00}] = req_data;
		end
		mdl_dirty[req_index] = exp_hit ? (mdl_dirty[req_index] || req_we) : req_we;
		mdl_valid[req_index] = 1'b1;
		mdl_tag[req_index]   = req_tag;
		test_count_o++;
		$display("test %0d %s 0x%08h %s %s", test_count_o, req_we ? "write" : "read",
			req_addr, exp_hit ? "hit" : "miss", error_count_o == req_errors ? "ok" : "mismatch");
		in_req = 1'b0;
	endtask

	always @(negedge clk_i) begin
		if (!rst_n_i) begin
			in_req        = 1'b0;
			test_count_o  = 0;
			error_count_o = 0;
			for (int i = 0; i < `LINE_COUNT; i++) begin
				mdl_valid[i] = 1'b0;
				mdl_dirty[i] = 1'b0;
			end
		end else begin
			// outside a request the cache must be quiet
			if (!in_req && (cache_ack_o || dram_cs_o)) begin
				report_error($sformatf("cache active outside a request, ack %b dram_cs %b",
					cache_ack_o, dram_cs_o));
			end
			if (!in_req && cache_cs_i) begin
				start_request();
			end else if (in_req) begin
				cycles++;
				if (dram_ack_i) begin
					check_dram();
				end
				if (cache_ack_o) begin
					finish_request();
				end
			end
		end
	end

endmodule

// File: sim/l1_cache_tb.sv
`timescale 1ns/1ps
`include "l1_cache_settings.svh"

module l1_cache_tb;

	localparam int TIMEOUT_CYCLES  = 200;
	localparam int RANDOM_REQUESTS = 400;

	logic                       clk_i;
	logic                       rst_n_i;
	logic [`ADDR_WIDTH-1:0]     cache_addr_i;
	logic                       cache_cs_i;
	logic                       cache_we_i;
	logic                       cache_ack_o;
	logic [`CPU_DATA_WIDTH-1:0] cache_data_i;
	logic [`CPU_DATA_WIDTH-1:0] cache_data_o;
	logic [`ADDR_WIDTH-1:0]     dram_addr_o;
	logic                       dram_cs_o;
	logic                       dram_we_o;
	logic                       dram_ack_i;
	logic [`MEM_DATA_WIDTH-1:0] dram_data_i;
	logic [`MEM_DATA_WIDTH-1:0] dram_data_o;

	integer       seed = 32'h46f7;
	int           test_count;
	int           monitor_errors;
	int           error_count;
	logic [21:0]  tag_pool [4];
	// sparse dram, keyed by line address
	logic [255:0] dram_mem [logic [26:0]];

	l1_cache l1_cache_i (.*);

	l1_cache_monitor monitor_i (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.cache_addr_i  (cache_addr_i),
		.cache_cs_i    (cache_cs_i),
		.cache_we_i    (cache_we_i),
		.cache_ack_o   (cache_ack_o),
		.cache_data_i  (cache_data_i),
		.cache_data_o  (cache_data_o),
		.dram_addr_o   (dram_addr_o),
		.dram_cs_o     (dram_cs_o),
		.dram_we_o     (dram_we_o),
		.dram_ack_i    (dram_ack_i),
		.dram_data_o   (dram_data_o),
		.test_count_o  (test_count),
		.error_count_o (monitor_errors)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#20 clk_i = ~clk_i;
		end
	end

	function automatic logic [31:0] pattern_word(input logic [31:0] addr);
		return {addr[31:2], 2'b00} ^ 32'h3c5a_96e1;
	endfunction

	function automatic logic [255:0] dram_line(input logic [31:0] line_addr);
		logic [255:0] line;
		if (dram_mem.exists(line_addr[31:5])) begin
			line = dram_mem[line_addr[31:5]];
		end else begin
			for (int w = 0; w < 8; w++) begin
				line[w*32 +: 32] = pattern_word(line_addr + 32'(w * 4));
			end
		end
		return line;
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$finish;
	endtask

	task automatic cpu_access(input logic [31:0] addr, input logic we, input logic [31:0] data);
		int wait_cycles;
		@(posedge clk_i);
		#2;
		cache_addr_i = addr;
		cache_we_i   = we;
		cache_data_i = data;
		cache_cs_i   = 1'b1;
		wait_cycles  = 0;
		@(negedge clk_i);
		while (!cache_ack_o && wait_cycles < TIMEOUT_CYCLES) begin
			@(negedge clk_i);
			wait_cycles++;
		end
		if (!cache_ack_o) begin
			abort_run($sformatf("no cache ack within %0d cycles for address 0x%08h",
				TIMEOUT_CYCLES, addr));
		end else begin
			@(posedge clk_i);
			#2;
			cache_cs_i = 1'b0;
		end
	endtask

	// answers each dram request after 1 to 6 cycles
	initial begin : dram_responder
		int latency;
		dram_ack_i  = 1'b0;
		dram_data_i = '0;
		forever begin
			@(negedge clk_i);
			if (rst_n_i && dram_cs_o) begin
				latency = 1 + ($unsigned($random(seed)) % 6);
				repeat (latency) @(posedge clk_i);
				#2;
				if (dram_we_o) begin
					dram_mem[dram_addr_o[31:5]] = dram_data_o;
				end else begin
					dram_data_i = dram_line(dram_addr_o);
				end
				dram_ack_i = 1'b1;
				@(posedge clk_i);
				#2;
				dram_ack_i = 1'b0;
			end
		end
	end

	initial begin : cpu_driver
		int          tag_sel;
		int          index;
		logic [31:0] word;
		logic [31:0] wdata;
		logic        we;
		rst_n_i      = 1'b0;
		cache_cs_i   = 1'b0;
		cache_we_i   = 1'b0;
		cache_addr_i = '0;
		cache_data_i = '0;
		tag_pool     = '{22'h000010, 22'h00048d, 22'h2af35a, 22'h3fffff};
		repeat (3) @(posedge clk_i);
		#2;
		rst_n_i = 1'b1;

		// cold miss, then the same word again
		cpu_access(32'h0000_4024, 1'b0, 32'h0);
		cpu_access(32'h0000_4024, 1'b0, 32'h0);
		// write one word, read it back and its neighbours
		cpu_access(32'h0000_4028, 1'b1, 32'hdead_beef);
		cpu_access(32'h0000_4028, 1'b0, 32'h0);
		cpu_access(32'h0000_4024, 1'b0, 32'h0);
		cpu_access(32'h0000_402c, 1'b0, 32'h0);
		// same index with another tag, dirty victim
		cpu_access(32'h0012_3424, 1'b0, 32'h0);
		// clean victim this time
		cpu_access(32'h0abc_d424, 1'b0, 32'h0);
		cpu_access(32'h0000_4028, 1'b0, 32'h0);

		for (int n = 0; n < RANDOM_REQUESTS; n++) begin
			tag_sel = $unsigned($random(seed)) % 4;
			index   = $unsigned($random(seed)) % 4;
			word    = $random(seed);
			we      = $random(seed);
			wdata   = $random(seed);
			cpu_access({tag_pool[tag_sel], index[4:0], word[2:0], 2'b00}, we, wdata);
		end

		repeat (2) @(posedge clk_i);
		error_count = monitor_errors + l1_cache_i.checker_i.fail_count;
		$display("%0d tests, %0d errors", test_count, error_count);
		if (error_count == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

// File: source/l1_cache_sram.sv
`timescale 1ns/1ps

module l1_cache_sram #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 32
) (
	input  logic                     clk_i,
	input  logic                     rst_n_i,
	input  logic [$clog2(DEPTH)-1:0] addr_i,
	input  logic                     we_i,
	input  logic [WIDTH-1:0]         data_i,
	output logic [WIDTH-1:0]         data_o
);

	logic [WIDTH-1:0] mem_q [DEPTH];

	// registered read, new data passes straight through on a write
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			mem_q  <= '{default: '0};
			data_o <= '0;
		end else if (we_i) begin
			mem_q[addr_i] <= data_i;
			data_o        <= data_i;
		end else begin
			data_o <= mem_q[addr_i];
		end
	end

endmodule
